/* hw/vseg_defines.svh */
// buffer depth, opcode and lumop constants for the segment expander; include in every RTL file.
`ifndef VSEG_DEFINES_SVH
`define VSEG_DEFINES_SVH

// the largest segment has nf=7 and so eight fields.
`define VSEG_MAX_FIELDS 8

// LOAD-FP and STORE-FP major opcodes.
`define VSEG_OP_LOAD_FP  7'b0000111
`define VSEG_OP_STORE_FP 7'b0100111

// lumop of the whole-register load.
`define VSEG_LUMOP_WHOLE 5'b01000

`endif

/* hw/vseg_pkg.sv */
// shared types for the vector segment expander; imported by every RTL module.
`default_nettype none
`include "vseg_defines.svh"

package vseg_pkg;

  // plain data or address word.
  typedef logic [31:0] word_t;

  // register-group multiplier in the vlmul encoding of vtype.
  // reserved and fractional codes are mapped to LMUL1 by the consumers.
  typedef enum logic [2:0] {
    LMUL1 = 3'b000,
    LMUL2 = 3'b001,
    LMUL4 = 3'b010,
    LMUL8 = 3'b011
  } vlmul_t;

  // selected element width in the vsew encoding of vtype.
  typedef enum logic [2:0] {
    SEW8  = 3'b000,
    SEW16 = 3'b001,
    SEW32 = 3'b010
  } sew_t;

  // width field codes of vector loads and stores.
  typedef enum logic [2:0] {
    WIDTH8  = 3'd0,
    WIDTH16 = 3'd5,
    WIDTH32 = 3'd6
  } width_t;

  // vector memory instruction fields from msb to lsb.
  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] lumop_rs2;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] rd;
    logic [6:0] opcode;
  } vmem_fields_t;

  // one issued micro-op.
  typedef struct packed {
    word_t      instr;
    word_t      addr;
    logic [2:0] field_idx;
    logic       last;
  } uop_t;

endpackage

`default_nettype wire

/* hw/vmem_decoder.sv */
// combinational decoder that splits a raw instruction into fields and flags vector memory ops.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module vmem_decoder (
  input  vseg_pkg::word_t        instr,
  output vseg_pkg::vmem_fields_t fields,
  output logic                   is_vector
);

  import vseg_pkg::*;

  logic opcode_hit;
  logic width_hit;

  assign fields = vmem_fields_t'(instr);

  // both vector memory classes share the FP load/store opcodes.
  assign opcode_hit = (fields.opcode == `VSEG_OP_LOAD_FP) ||
                      (fields.opcode == `VSEG_OP_STORE_FP);

  // other width codes under the same opcodes are scalar FP accesses.
  always_comb begin
    case (fields.width)
      WIDTH8:  width_hit = 1'b1;
      WIDTH16: width_hit = 1'b1;
      WIDTH32: width_hit = 1'b1;
      default: width_hit = 1'b0;
    endcase
  end

  assign is_vector = opcode_hit & width_hit;

endmodule

`default_nettype wire

/* hw/vtype_reg.sv */
// vtype register that holds LMUL and SEW for the expander and flags illegal vtype writes.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module vtype_reg (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              vtype_wr,
  input  vseg_pkg::word_t   vtype_word,
  output vseg_pkg::vlmul_t  lmul,
  output vseg_pkg::sew_t    sew,
  output logic              vtype_ill
);

  import vseg_pkg::*;

  logic [2:0] vlmul_raw;
  logic [2:0] vsew_raw;
  vlmul_t     next_lmul;
  sew_t       next_sew;
  logic       lmul_ok;
  logic       sew_ok;
  logic       next_ill;

  assign vlmul_raw = vtype_word[2:0];
  assign vsew_raw  = vtype_word[5:3];

  // fractional settings run as LMUL1 and 3'b100 is reserved.
  always_comb begin
    lmul_ok = 1'b1;
    case (vlmul_raw)
      3'b000:  next_lmul = LMUL1;
      3'b001:  next_lmul = LMUL2;
      3'b010:  next_lmul = LMUL4;
      3'b011:  next_lmul = LMUL8;
      3'b101, 3'b110, 3'b111: next_lmul = LMUL1;
      default: begin
        next_lmul = LMUL1;
        lmul_ok   = 1'b0;
      end
    endcase
  end

  // only 8, 16 and 32 bit elements are supported.
  always_comb begin
    sew_ok = 1'b1;
    case (vsew_raw)
      3'b000:  next_sew = SEW8;
      3'b001:  next_sew = SEW16;
      3'b010:  next_sew = SEW32;
      default: begin
        next_sew = SEW8;
        sew_ok   = 1'b0;
      end
    endcase
  end

  assign next_ill = ~(lmul_ok & sew_ok);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lmul      <= LMUL1;
      sew       <= SEW8;
      vtype_ill <= 1'b0;
    end else if (vtype_wr) begin
      lmul      <= next_ill ? LMUL1 : next_lmul;
      sew       <= next_ill ? SEW8 : next_sew;
      vtype_ill <= next_ill;
    end
  end

  // a reserved vlmul write leaves LMUL1 and the illegal flag.
  lmul_legal_a: assert property (@(posedge CLK) disable iff (!nRST)
    (vtype_wr && vtype_word[2:0] == 3'b100) |=> (vtype_ill && lmul == LMUL1));

endmodule

`default_nettype wire

/* hw/segment_loadstore_microop.sv */
// micro-op buffer that expands a segment load/store into single-field ops and tracks the offset.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module segment_loadstore_microop (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vseg_pkg::vmem_fields_t fields,
  input  logic                   shift_ena,
  input  logic                   is_vector,
  input  vseg_pkg::vlmul_t       lmul,
  input  vseg_pkg::sew_t         sew,
  output logic                   busy,
  output logic                   segment_ena,
  output logic [2:0]             nf_counter,
  output vseg_pkg::word_t        segment_instr,
  output vseg_pkg::word_t        base_address_offset
);

  import vseg_pkg::*;

  localparam int DEPTH = `VSEG_MAX_FIELDS;

  vmem_fields_t [DEPTH-1:0] buffer;
  vmem_fields_t [DEPTH-1:0] load_word;
  logic       is_segment;
  logic       is_segment_q;
  logic       load_ena;
  logic       indexed;
  logic       last_field;
  logic [3:0] rd_step;
  logic [3:0] remaining;
  logic [2:0] eew_bytes;
  logic [2:0] load_eew_bytes;

  assign is_segment = (fields.nf != 3'd0) &&
                      (fields.lumop_rs2 != `VSEG_LUMOP_WHOLE) && is_vector;

  // loads on the rising edge only so a held instruction does not restart.
  assign load_ena = is_segment & ~is_segment_q;

  assign indexed    = (fields.mop == 2'b01) || (fields.mop == 2'b11);
  assign last_field = (remaining == 4'd1);

  // registers per group.
  always_comb begin
    case (lmul)
      LMUL1:   rd_step = 4'd1;
      LMUL2:   rd_step = 4'd2;
      LMUL4:   rd_step = 4'd4;
      LMUL8:   rd_step = 4'd8;
      default: rd_step = 4'd1;
    endcase
  end

  // indexed forms use SEW for the data element width.
  always_comb begin
    load_eew_bytes = 3'd1;
    if (indexed) begin
      case (sew)
        SEW16:   load_eew_bytes = 3'd2;
        SEW32:   load_eew_bytes = 3'd4;
        default: load_eew_bytes = 3'd1;
      endcase
    end else begin
      case (fields.width)
        WIDTH16: load_eew_bytes = 3'd2;
        WIDTH32: load_eew_bytes = 3'd4;
        default: load_eew_bytes = 3'd1;
      endcase
    end
  end

  // field k targets rd + k groups and wraps in the register file.
  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      load_word[k]    = fields;
      load_word[k].nf = 3'd0;
      load_word[k].rd = fields.rd + 5'(k * rd_step);
    end
  end

  assign segment_instr = load_ena ? load_word[0] : buffer[0];
  assign segment_ena   = is_segment | busy;

  // a count of eight shows as 0 on the 3-bit port.
  assign nf_counter = remaining[2:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      is_segment_q        <= 1'b0;
      busy                <= 1'b0;
      remaining           <= '0;
      base_address_offset <= '0;
      eew_bytes           <= 3'd1;
    end else begin
      is_segment_q <= is_segment;
      if (busy && shift_ena) begin
        remaining           <= remaining - 4'd1;
        busy                <= !last_field;
        base_address_offset <= last_field ? '0 :
                               base_address_offset + {29'd0, eew_bytes};
      end else if (load_ena) begin
        remaining           <= {1'b0, fields.nf} + 4'd1;
        busy                <= 1'b1;
        base_address_offset <= '0;
        eew_bytes           <= load_eew_bytes;
      end
    end
  end

  // field 0 always sits at the bottom.
  always_ff @(posedge CLK) begin
    if (busy && shift_ena) begin
      buffer <= {vmem_fields_t'('0), buffer[DEPTH-1:1]};
    end else if (load_ena) begin
      buffer <= load_word;
    end
  end

  busy_count_a: assert property (@(posedge CLK) disable iff (!nRST)
    busy |-> remaining != 4'd0);

  count_rise_a: assert property (@(posedge CLK) disable iff (!nRST)
    (remaining > $past(remaining)) |-> $past(load_ena));

endmodule

`default_nettype wire

/* hw/segment_uop_issue.sv */
// issue register that captures each accepted micro-op with its address, field index and last flag.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module segment_uop_issue (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            accept,
  input  logic            busy,
  input  vseg_pkg::word_t segment_instr,
  input  vseg_pkg::word_t base_address_offset,
  input  vseg_pkg::word_t rs1_value,
  input  logic [2:0]      nf_counter,
  input  logic [2:0]      nf,
  output vseg_pkg::uop_t  uop,
  output logic            uop_valid
);

  import vseg_pkg::*;

  logic       fire;
  logic [2:0] field_idx;

  // strobes outside an expansion are dropped.
  assign fire = accept & busy;

  // the subtraction wraps modulo 8 and gives field 0 for nf=7 at a count of 0.
  assign field_idx = nf + 3'd1 - nf_counter;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= fire;
    end
  end

  // offset is sampled before the buffer adds the next step.
  always_ff @(posedge CLK) begin
    if (fire) begin
      uop.instr     <= segment_instr;
      uop.addr      <= rs1_value + base_address_offset;
      uop.field_idx <= field_idx;
      uop.last      <= (nf_counter == 3'd1);
    end
  end

  // back-to-back micro-ops carry consecutive field indices.
  back_to_back_a: assert property (@(posedge CLK) disable iff (!nRST)
    (uop_valid && $past(uop_valid)) |-> (uop.field_idx == $past(uop.field_idx) + 3'd1));

endmodule

`default_nettype wire

/* hw/vseg_expand_top.sv */
// top level of the segment expander; connects decoder, vtype register, buffer and issue stage.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module vseg_expand_top (
  input  logic            CLK,
  input  logic            nRST,
  input  vseg_pkg::word_t instr,
  input  vseg_pkg::word_t rs1_value,
  input  logic            vtype_wr,
  input  vseg_pkg::word_t vtype_word,
  input  logic            uop_accept,
  output logic            busy,
  output logic            segment_ena,
  output vseg_pkg::word_t segment_instr,
  output vseg_pkg::uop_t  uop,
  output logic            uop_valid,
  output logic            vtype_ill
);

  import vseg_pkg::*;

  vmem_fields_t fields;
  logic         is_vector;
  vlmul_t       lmul;
  sew_t         sew;
  logic [2:0]   nf_counter;
  word_t        base_address_offset;

  vmem_decoder u_decoder (
    .instr     (instr),
    .fields    (fields),
    .is_vector (is_vector)
  );

  vtype_reg u_vtype (
    .CLK        (CLK),
    .nRST       (nRST),
    .vtype_wr   (vtype_wr),
    .vtype_word (vtype_word),
    .lmul       (lmul),
    .sew        (sew),
    .vtype_ill  (vtype_ill)
  );

  // the memory stage strobe shifts the buffer.
  segment_loadstore_microop u_buffer (
    .CLK                 (CLK),
    .nRST                (nRST),
    .fields              (fields),
    .shift_ena           (uop_accept),
    .is_vector           (is_vector),
    .lmul                (lmul),
    .sew                 (sew),
    .busy                (busy),
    .segment_ena         (segment_ena),
    .nf_counter          (nf_counter),
    .segment_instr       (segment_instr),
    .base_address_offset (base_address_offset)
  );

  segment_uop_issue u_issue (
    .CLK                 (CLK),
    .nRST                (nRST),
    .accept              (uop_accept),
    .busy                (busy),
    .segment_instr       (segment_instr),
    .base_address_offset (base_address_offset),
    .rs1_value           (rs1_value),
    .nf_counter          (nf_counter),
    .nf                  (fields.nf),
    .uop                 (uop),
    .uop_valid           (uop_valid)
  );

endmodule

`default_nettype wire

/* bench/vseg_expand_tb.sv */
// directed testbench for the segment expander; compile with filelist.f, top is vseg_expand_tb.
`timescale 1ns/1ps
`default_nettype none
`include "vseg_defines.svh"

module vseg_expand_tb;

  import vseg_pkg::*;

  localparam int          CLK_PERIOD = 10;
  localparam int          NUM_TESTS  = 6;
  localparam logic [31:0] NOP        = 32'h0000_0013;

  logic        CLK;
  logic        nRST;
  word_t       instr;
  word_t       rs1_value;
  logic        vtype_wr;
  word_t       vtype_word;
  logic        uop_accept;
  logic        busy;
  logic        segment_ena;
  word_t       segment_instr;
  uop_t        uop;
  logic        uop_valid;
  logic        vtype_ill;
  logic [31:0] lfsr_state = 32'h8c3958e1;
  // group size and element bytes the current vtype should give.
  int          lmul_regs;
  int          sew_bytes;

  vseg_expand_top uut (
    .CLK           (CLK),
    .nRST          (nRST),
    .instr         (instr),
    .rs1_value     (rs1_value),
    .vtype_wr      (vtype_wr),
    .vtype_word    (vtype_word),
    .uop_accept    (uop_accept),
    .busy          (busy),
    .segment_ena   (segment_ena),
    .segment_instr (segment_instr),
    .uop           (uop),
    .uop_valid     (uop_valid),
    .vtype_ill     (vtype_ill)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic report_failure();
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    report_failure();
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_instr(input logic [2:0] nf, input logic [1:0] mop,
                                             input logic [4:0] lumop, input logic [2:0] width,
                                             input logic [4:0] rd, input logic store);
    logic [6:0] opcode;
    opcode = store ? `VSEG_OP_STORE_FP : `VSEG_OP_LOAD_FP;
    return {nf, 1'b0, mop, 1'b1, lumop, 5'd10, width, rd, opcode};
  endfunction

  // expected micro-op k has nf cleared and rd moved by k groups.
  function automatic logic [31:0] field_word(input logic [31:0] ins, input int k);
    logic [4:0] rd_k;
    rd_k = ins[11:7] + 5'(k * lmul_regs);
    return {3'b000, ins[28:12], rd_k, ins[6:0]};
  endfunction

  function automatic int width_bytes(input logic [2:0] width);
    case (width)
      3'd5:    return 2;
      3'd6:    return 4;
      default: return 1;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic set_vtype(input logic [31:0] word);
    bit ill;
    int regs;
    int bytes;
    ill = 1'b0;
    case (word[2:0])
      3'd1:    regs = 2;
      3'd2:    regs = 4;
      3'd3:    regs = 8;
      3'd4: begin
        regs = 1;
        ill  = 1'b1;
      end
      default: regs = 1;
    endcase
    case (word[5:3])
      3'd0:    bytes = 1;
      3'd1:    bytes = 2;
      3'd2:    bytes = 4;
      default: begin
        bytes = 1;
        ill   = 1'b1;
      end
    endcase
    @(posedge CLK);
    vtype_wr   <= 1'b1;
    vtype_word <= word;
    @(posedge CLK);
    vtype_wr <= 1'b0;
    @(negedge CLK);
    check_value("vtype_ill", vtype_ill, ill);
    lmul_regs = ill ? 1 : regs;
    sew_bytes = ill ? 1 : bytes;
  endtask

  task automatic idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge CLK);
      instr      <= NOP;
      uop_accept <= 1'b0;
      @(negedge CLK);
      check_value("busy", busy, 0);
      check_value("uop_valid", uop_valid, 0);
    end
  endtask

  // holds an instruction and strobes every cycle but the last; nothing may issue.
  task automatic hold_and_check(input logic [31:0] ins, input int cycles, input logic exp_ena);
    for (int i = 0; i < cycles; i++) begin
      @(posedge CLK);
      instr      <= ins;
      uop_accept <= (i != cycles - 1);
      @(negedge CLK);
      check_value("busy", busy, 0);
      check_value("uop_valid", uop_valid, 0);
      check_value("segment_ena", segment_ena, exp_ena);
    end
  endtask

  task automatic run_segment(input logic [31:0] ins, input bit use_gaps);
    int          total;
    int          issued;
    int          seen;
    int          gap;
    int          eew;
    bit          cur;
    bit          prev;
    logic [31:0] base;
    total  = int'(ins[31:29]) + 1;
    eew    = ins[26] ? sew_bytes : width_bytes(ins[14:12]);
    base   = rand_bits(32);
    issued = 0;
    seen   = 0;
    prev   = 1'b0;
    gap    = use_gaps ? int'(rand_bits(2)) : 0;
    @(posedge CLK);
    instr      <= ins;
    rs1_value  <= base;
    uop_accept <= 1'b0;
    @(negedge CLK);
    // field 0 is visible before busy rises.
    check_value("busy", busy, 0);
    check_value("segment_ena", segment_ena, 1);
    check_value("segment_instr", segment_instr, field_word(ins, 0));
    while (seen < total) begin
      @(posedge CLK);
      cur = (issued < total) && (gap == 0);
      uop_accept <= cur;
      if (cur) begin
        issued++;
        gap = use_gaps ? int'(rand_bits(2)) : 0;
      end else if (gap > 0) begin
        gap--;
      end
      @(negedge CLK);
      check_value("busy", busy, (issued - int'(cur)) < total);
      if (busy) begin
        check_value("segment_instr", segment_instr, field_word(ins, issued - int'(cur)));
      end
      check_value("uop_valid", uop_valid, prev);
      if (prev) begin
        check_value("uop.instr", uop.instr, field_word(ins, seen));
        check_value("uop.addr", uop.addr, base + 32'(seen * eew));
        check_value("uop.field_idx", uop.field_idx, seen);
        check_value("uop.last", uop.last, seen == total - 1);
        seen++;
      end
      prev = cur;
    end
  endtask

  task automatic reset_state_test();
    @(negedge CLK);
    check_value("busy", busy, 0);
    check_value("uop_valid", uop_valid, 0);
    check_value("vtype_ill", vtype_ill, 0);
    set_vtype(32'h0000_0000);
    run_segment(make_instr(3'd3, 2'b00, 5'd0, WIDTH32, 5'd4, 1'b0), 1'b0);
    idle(1);
  endtask

  task automatic field_sweep_test();
    for (int l = 0; l < 4; l++) begin
      set_vtype(32'(l));
      for (int nf = 1; nf < 8; nf++) begin
        run_segment(make_instr(3'(nf), 2'b00, 5'd0, WIDTH32, 5'(20 + nf + l), 1'(nf % 2)),
                    1'b0);
        idle(1);
      end
    end
  endtask

  task automatic address_test();
    // LMUL2 with 16-bit elements.
    set_vtype(32'h0000_0009);
    run_segment(make_instr(3'd7, 2'b00, 5'd0, WIDTH8, 5'd2, 1'b0), 1'b1);
    idle(1);
    run_segment(make_instr(3'd4, 2'b10, 5'd7, WIDTH16, 5'd8, 1'b1), 1'b1);
    idle(1);
    run_segment(make_instr(3'd5, 2'b01, 5'd3, WIDTH32, 5'd16, 1'b0), 1'b1);
    idle(1);
    // ordered indexed with 32-bit elements.
    set_vtype(32'h0000_0010);
    run_segment(make_instr(3'd6, 2'b11, 5'd1, WIDTH8, 5'd24, 1'b1), 1'b1);
    idle(1);
  endtask

  task automatic non_segment_test();
    hold_and_check(make_instr(3'd0, 2'b00, 5'd0, WIDTH16, 5'd1, 1'b0), 4, 1'b0);
    idle(1);
    hold_and_check(make_instr(3'd1, 2'b00, `VSEG_LUMOP_WHOLE, WIDTH32, 5'd8, 1'b0), 4, 1'b0);
    idle(1);
    // scalar FLW encoding.
    hold_and_check(make_instr(3'd2, 2'b00, 5'd0, 3'b010, 5'd3, 1'b0), 4, 1'b0);
    idle(2);
  endtask

  task automatic restart_test();
    logic [31:0] ins;
    set_vtype(32'h0000_0002);
    ins = make_instr(3'd2, 2'b00, 5'd0, WIDTH16, 5'd28, 1'b0);
    run_segment(ins, 1'b1);
    hold_and_check(ins, 6, 1'b1);
    idle(1);
    run_segment(ins, 1'b1);
    idle(1);
  endtask

  task automatic illegal_vtype_test();
    // vlmul 100 is reserved.
    set_vtype(32'h0000_000c);
    run_segment(make_instr(3'd3, 2'b00, 5'd0, WIDTH8, 5'd5, 1'b1), 1'b0);
    idle(1);
    set_vtype(32'h0000_0003);
  endtask

  initial begin
    CLK        = 1'b0;
    nRST       = 1'b0;
    instr      = NOP;
    rs1_value  = '0;
    vtype_wr   = 1'b0;
    vtype_word = '0;
    uop_accept = 1'b0;
    lmul_regs  = 1;
    sew_bytes  = 1;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    reset_state_test();
    field_sweep_test();
    address_test();
    non_segment_test();
    restart_test();
    illegal_vtype_test();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/vseg_pkg.sv
hw/vmem_decoder.sv
hw/vtype_reg.sv
hw/segment_loadstore_microop.sv
hw/segment_uop_issue.sv
hw/vseg_expand_top.sv
bench/vseg_expand_tb.sv
